// ==== source/usb_host_config.svh ====
`ifndef USB_HOST_CONFIG_SVH
`define USB_HOST_CONFIG_SVH

// ------------------------------------------------------------
// host timing, in clk cycles
// ------------------------------------------------------------

// one frame at 60 MHz
`define USB_SOF_PERIOD 60000

// wait for the PHY to take the bus after stp
`define USB_RX_DIR_TIMEOUT 60

// upper bound on a single receive
`define USB_RX_NXT_TIMEOUT 30000

// wait for the PHY to release the bus before ACK
`define USB_TX_DIR_TIMEOUT 60

// ------------------------------------------------------------
// control transfers
// ------------------------------------------------------------

`define USB_SETUP_LEN 8

`endif

// ==== source/ulpi_pkg.sv ====
package ulpi_pkg;

    // ------------------------------------------------------------
    // PHY side view of the link
    // ------------------------------------------------------------

    // linestate bits [1:0] of an RX_CMD byte
    typedef enum logic [1:0] {
        LS_SE0 = 2'b00,
        LS_J   = 2'b01,
        LS_K   = 2'b10,
        LS_SE1 = 2'b11
    } linestate_t;

    // decoded RX_CMD byte
    // bit 4 is RxActive, bits [5:4] = 2'b10 flag a host disconnect
    typedef struct packed {
        logic       host_disconnect;
        logic       rx_error;
        logic       rx_active;
        linestate_t line_state;
    } rx_cmd_t;

endpackage

// ==== source/usb_proto_pkg.sv ====
package usb_proto_pkg;

    // ------------------------------------------------------------
    // packet identifiers
    // ------------------------------------------------------------

    typedef enum logic [7:0] {
        PID_SOF   = 8'h45,
        PID_SETUP = 8'h4D,
        PID_IN    = 8'h49,
        PID_DATA0 = 8'h43,
        PID_DATA1 = 8'h4B,
        PID_ACK   = 8'h42
    } pid_t;

    // scheduled transactions, listed in priority order
    typedef enum logic [1:0] {
        XFER_SETUP_ADDR,
        XFER_SETUP_CFG,
        XFER_SOF,
        XFER_IN
    } xfer_kind_t;

    typedef enum logic [3:0] {
        ST_IDLE, ST_TX_TOKEN1, ST_TX_TOKEN2, ST_TX_TOKEN3, ST_TX_IFS,
        ST_TX_PID, ST_TX_DATA, ST_TX_CRC1, ST_TX_CRC2, ST_RX_WAIT1,
        ST_RX_WAIT2, ST_RX_DATA, ST_TX_WAIT, ST_TX_ACK, ST_TX_TURNAROUND
    } fsm_state_t;

    // 8-byte setup stage payload
    typedef struct packed {
        logic [7:0]  req_type;
        logic [7:0]  request;
        logic [15:0] value;
        logic [15:0] index;
        logic [15:0] length;
    } setup_req_t;

    // device gets address 1
    localparam setup_req_t SET_ADDR_REQ = '{8'h00, 8'h05, 16'h0001, 16'h0000, 16'h0000};
    // configuration 1
    localparam setup_req_t SET_CFG_REQ  = '{8'h00, 8'h09, 16'h0001, 16'h0000, 16'h0000};

    localparam logic [6:0] DEV_ADDR0 = 7'h00;
    localparam logic [6:0] DEV_ADDR1 = 7'h01;
    localparam logic [3:0] EP0       = 4'h0;
    localparam logic [3:0] EP1       = 4'h1;

    // CRC fields are not computed, fixed placeholders
    localparam logic [4:0]  CRC5  = 5'h1F;
    localparam logic [15:0] CRC16 = 16'hFFFF;

endpackage

// ==== source/ulpi_link_if.sv ====
interface ulpi_link_if;

    // dir toggled since last cycle
    logic               turnaround;
    logic               rx_cmd_valid;
    ulpi_pkg::rx_cmd_t  rx_cmd;
    // error or disconnect reported by the PHY
    logic               abort;
    // nxt edge while receiving, marks the PID byte
    logic               pid_strobe;

    modport decoder (
        output turnaround, rx_cmd_valid, rx_cmd, abort, pid_strobe
    );

    modport fsm (
        input turnaround, rx_cmd_valid, rx_cmd, abort, pid_strobe
    );

endinterface

// ==== source/usb_sched_if.sv ====
interface usb_sched_if;

    // scheduler side
    logic                       pending;
    usb_proto_pkg::xfer_kind_t  kind;
    logic [10:0]                frame_num;

    // one-cycle pulses from the packet FSM
    logic                       token_done;
    logic                       data_done;
    logic                       sof_done;

    modport sched (
        output pending, kind, frame_num,
        input  token_done, data_done, sof_done
    );

    modport fsm (
        input  pending, kind, frame_num,
        output token_done, data_done, sof_done
    );

endinterface

// ==== source/ulpi_rx_cmd_decoder.sv ====
module ulpi_rx_cmd_decoder (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  data_i,
    input  logic        dir_i,
    input  logic        nxt_i,
    ulpi_link_if.decoder link,
    output logic        connect_o,
    output logic        connect_pulse_o
);

    logic                   dir_q;
    logic                   nxt_q;
    logic                   turnaround;
    logic                   rx_cmd_valid;
    ulpi_pkg::rx_cmd_t      rx_cmd;
    ulpi_pkg::linestate_t   line_state_q;
    logic                   connect_q;
    logic                   se0_to_j;

    always_ff @(posedge clk) begin
        if (rst) begin
            dir_q <= 1'b0;
            nxt_q <= 1'b0;
        end else begin
            dir_q <= dir_i;
            nxt_q <= nxt_i;
        end
    end

    // ------------------------------------------------------------
    // RX_CMD decode
    // ------------------------------------------------------------

    assign turnaround   = dir_q ^ dir_i;
    assign rx_cmd_valid = dir_i && !nxt_i && !turnaround;

    assign rx_cmd.line_state      = ulpi_pkg::linestate_t'(data_i[1:0]);
    assign rx_cmd.rx_active       = data_i[4];
    assign rx_cmd.rx_error        = (data_i[5:4] == 2'b11);
    assign rx_cmd.host_disconnect = (data_i[5:4] == 2'b10);

    assign link.turnaround   = turnaround;
    assign link.rx_cmd_valid = rx_cmd_valid;
    assign link.rx_cmd       = rx_cmd;
    assign link.abort        = rx_cmd_valid && (rx_cmd.rx_error || rx_cmd.host_disconnect);
    assign link.pid_strobe   = (nxt_q ^ nxt_i) && dir_i && !turnaround;

    // ------------------------------------------------------------
    // attach tracking
    // ------------------------------------------------------------

    // device pulls D+ up, line goes SE0 -> J
    assign se0_to_j = rx_cmd_valid && (line_state_q == ulpi_pkg::LS_SE0)
                      && (rx_cmd.line_state == ulpi_pkg::LS_J);

    always_ff @(posedge clk) begin
        if (rst) begin
            line_state_q <= ulpi_pkg::LS_SE0;
            connect_q    <= 1'b0;
        end else begin
            if (rx_cmd_valid) begin
                line_state_q <= rx_cmd.line_state;
            end
            if (rx_cmd_valid && rx_cmd.host_disconnect) begin
                connect_q <= 1'b0;
            end else if (se0_to_j) begin
                connect_q <= 1'b1;
            end
        end
    end

    assign connect_o       = connect_q;
    assign connect_pulse_o = se0_to_j && !connect_q;

endmodule

// ==== source/usb_transfer_sched.sv ====
`include "usb_host_config.svh"

module usb_transfer_sched (
    input  logic        clk,
    input  logic        rst,
    input  logic        connect_pulse_i,
    input  logic        disconnect_i,
    usb_sched_if.sched  sched
);

    localparam int unsigned SOF_W = $clog2(`USB_SOF_PERIOD);

    logic                       setup_addr_q;
    logic                       setup_cfg_q;
    logic                       sof_q;
    logic                       in_q;
    // setup transaction whose data stage is running
    usb_proto_pkg::xfer_kind_t  active_kind_q;
    logic [SOF_W-1:0]           sof_cnt_q;
    logic                       sof_tick;
    logic [10:0]                frame_q;
    logic                       addr_stage_done;
    logic                       cfg_stage_done;

    // ------------------------------------------------------------
    // frame timer
    // ------------------------------------------------------------

    assign sof_tick = (sof_cnt_q == SOF_W'(`USB_SOF_PERIOD - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            sof_cnt_q <= '0;
            frame_q   <= '0;
        end else begin
            sof_cnt_q <= sof_tick ? '0 : sof_cnt_q + 1'b1;
            if (sched.sof_done) begin
                frame_q <= frame_q + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // pending flags
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (sched.token_done) begin
            active_kind_q <= sched.kind;
        end
    end

    assign addr_stage_done = sched.data_done
                             && (active_kind_q == usb_proto_pkg::XFER_SETUP_ADDR);
    assign cfg_stage_done  = sched.data_done
                             && (active_kind_q == usb_proto_pkg::XFER_SETUP_CFG);

    always_ff @(posedge clk) begin
        if (rst) begin
            setup_addr_q <= 1'b0;
            setup_cfg_q  <= 1'b0;
            sof_q        <= 1'b0;
            in_q         <= 1'b0;
        end else begin
            if (connect_pulse_i) begin
                setup_addr_q <= 1'b1;
            end else if (addr_stage_done) begin
                setup_addr_q <= 1'b0;
            end

            // SET_ADDRESS finished, configure next
            if (addr_stage_done) begin
                setup_cfg_q <= 1'b1;
            end else if (cfg_stage_done) begin
                setup_cfg_q <= 1'b0;
            end

            if (connect_pulse_i || sof_tick) begin
                sof_q <= 1'b1;
            end else if (sched.sof_done) begin
                sof_q <= 1'b0;
            end

            // IN polling starts after the first frame
            if (disconnect_i) begin
                in_q <= 1'b0;
            end else if (sched.sof_done) begin
                in_q <= 1'b1;
            end
        end
    end

    always_comb begin
        if (setup_addr_q) begin
            sched.kind = usb_proto_pkg::XFER_SETUP_ADDR;
        end else if (setup_cfg_q) begin
            sched.kind = usb_proto_pkg::XFER_SETUP_CFG;
        end else if (sof_q) begin
            sched.kind = usb_proto_pkg::XFER_SOF;
        end else begin
            sched.kind = usb_proto_pkg::XFER_IN;
        end
    end

    assign sched.pending   = setup_addr_q || setup_cfg_q || sof_q || in_q;
    assign sched.frame_num = frame_q;

endmodule

// ==== source/usb_packet_fsm.sv ====
`include "usb_host_config.svh"

module usb_packet_fsm (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  data_i,
    input  logic        dir_i,
    input  logic        nxt_i,
    ulpi_link_if.fsm    link,
    usb_sched_if.fsm    sched,
    input  logic        connected_i,
    output logic [7:0]  data_o,
    output logic        stp_o,
    output logic        new_read_o,
    output logic        data_store_valid_o,
    output logic [7:0]  data_store_o
);

    localparam int unsigned TMR_W     = $clog2(`USB_RX_NXT_TIMEOUT);
    localparam logic [3:0]  SETUP_LEN = 4'(`USB_SETUP_LEN);

    usb_proto_pkg::fsm_state_t  state_q;
    usb_proto_pkg::fsm_state_t  state_d;
    usb_proto_pkg::xfer_kind_t  kind_q;
    usb_proto_pkg::setup_req_t  setup_req;
    logic [3:0]                 byte_cnt_q;
    logic [3:0]                 setup_idx;
    logic [7:0]                 setup_byte;
    logic [TMR_W-1:0]           timer_q;
    logic                       timeout;
    logic                       pid_seen_q;
    logic [7:0]                 rx_pid_q;
    logic                       data_ok;
    logic                       rx_done;
    logic                       is_sof;
    logic                       is_in;
    logic [6:0]                 tok_addr;
    logic [3:0]                 tok_ep;

    // ------------------------------------------------------------
    // token and setup fields
    // ------------------------------------------------------------

    assign is_sof   = (kind_q == usb_proto_pkg::XFER_SOF);
    assign is_in    = (kind_q == usb_proto_pkg::XFER_IN);
    assign tok_addr = (kind_q == usb_proto_pkg::XFER_SETUP_ADDR) ? usb_proto_pkg::DEV_ADDR0
                                                                 : usb_proto_pkg::DEV_ADDR1;
    assign tok_ep   = is_in ? usb_proto_pkg::EP1 : usb_proto_pkg::EP0;

    assign setup_req = (kind_q == usb_proto_pkg::XFER_SETUP_ADDR) ? usb_proto_pkg::SET_ADDR_REQ
                                                                  : usb_proto_pkg::SET_CFG_REQ;
    assign setup_idx = SETUP_LEN - byte_cnt_q;

    // wire order, 16-bit fields low byte first
    always_comb begin
        case (setup_idx)
            4'd0:    setup_byte = setup_req.req_type;
            4'd1:    setup_byte = setup_req.request;
            4'd2:    setup_byte = setup_req.value[7:0];
            4'd3:    setup_byte = setup_req.value[15:8];
            4'd4:    setup_byte = setup_req.index[7:0];
            4'd5:    setup_byte = setup_req.index[15:8];
            4'd6:    setup_byte = setup_req.length[7:0];
            default: setup_byte = setup_req.length[15:8];
        endcase
    end

    // one timer for the three waits, cleared on every state change
    assign timeout =
        ((state_q == usb_proto_pkg::ST_RX_WAIT2)
            && (timer_q == TMR_W'(`USB_RX_DIR_TIMEOUT - 1)))
        || ((state_q == usb_proto_pkg::ST_RX_DATA)
            && (timer_q == TMR_W'(`USB_RX_NXT_TIMEOUT - 1)))
        || ((state_q == usb_proto_pkg::ST_TX_WAIT)
            && (timer_q == TMR_W'(`USB_TX_DIR_TIMEOUT - 1)));

    // PHY drops dir, or reports the receive as finished
    assign rx_done = (link.turnaround && !dir_i)
                     || (link.rx_cmd_valid && !link.rx_cmd.rx_active && pid_seen_q);
    assign data_ok = pid_seen_q && ((rx_pid_q == usb_proto_pkg::PID_DATA0)
                                    || (rx_pid_q == usb_proto_pkg::PID_DATA1));

    // ------------------------------------------------------------
    // next state and outputs
    // ------------------------------------------------------------

    always_comb begin
        state_d            = state_q;
        data_o             = 8'h00;
        stp_o              = 1'b0;
        new_read_o         = 1'b0;
        data_store_valid_o = 1'b0;
        sched.token_done   = 1'b0;
        sched.data_done    = 1'b0;
        sched.sof_done     = 1'b0;

        if (link.abort) begin
            state_d = usb_proto_pkg::ST_IDLE;
        end else begin
            case (state_q)
                usb_proto_pkg::ST_IDLE: begin
                    if (connected_i && sched.pending) begin
                        state_d = usb_proto_pkg::ST_TX_TOKEN1;
                    end
                end
                usb_proto_pkg::ST_TX_TOKEN1: begin
                    data_o = is_sof ? usb_proto_pkg::PID_SOF
                           : is_in  ? usb_proto_pkg::PID_IN : usb_proto_pkg::PID_SETUP;
                    if (nxt_i) begin
                        state_d = usb_proto_pkg::ST_TX_TOKEN2;
                    end
                end
                usb_proto_pkg::ST_TX_TOKEN2: begin
                    data_o = is_sof ? sched.frame_num[7:0] : {tok_addr, tok_ep[0]};
                    if (nxt_i) begin
                        state_d = usb_proto_pkg::ST_TX_TOKEN3;
                    end
                end
                usb_proto_pkg::ST_TX_TOKEN3: begin
                    data_o = is_sof ? {sched.frame_num[10:8], usb_proto_pkg::CRC5}
                                    : {tok_ep[3:1], usb_proto_pkg::CRC5};
                    if (nxt_i) begin
                        sched.sof_done   = is_sof;
                        sched.token_done = !is_sof;
                        state_d = is_in ? usb_proto_pkg::ST_RX_WAIT1 : usb_proto_pkg::ST_TX_IFS;
                    end
                end
                usb_proto_pkg::ST_TX_IFS: begin
                    stp_o   = 1'b1;
                    state_d = is_sof ? usb_proto_pkg::ST_IDLE : usb_proto_pkg::ST_TX_PID;
                end
                usb_proto_pkg::ST_TX_PID: begin
                    // setup stage is always DATA0
                    data_o = usb_proto_pkg::PID_DATA0;
                    if (nxt_i) begin
                        state_d = usb_proto_pkg::ST_TX_DATA;
                    end
                end
                usb_proto_pkg::ST_TX_DATA: begin
                    data_o = setup_byte;
                    if (nxt_i && (byte_cnt_q == 4'd1)) begin
                        state_d = usb_proto_pkg::ST_TX_CRC1;
                    end
                end
                usb_proto_pkg::ST_TX_CRC1: begin
                    data_o = usb_proto_pkg::CRC16[7:0];
                    if (nxt_i) begin
                        state_d = usb_proto_pkg::ST_TX_CRC2;
                    end
                end
                usb_proto_pkg::ST_TX_CRC2: begin
                    data_o = usb_proto_pkg::CRC16[15:8];
                    if (nxt_i) begin
                        sched.data_done = 1'b1;
                        state_d         = usb_proto_pkg::ST_RX_WAIT1;
                    end
                end
                usb_proto_pkg::ST_RX_WAIT1: begin
                    stp_o   = 1'b1;
                    state_d = usb_proto_pkg::ST_RX_WAIT2;
                end
                usb_proto_pkg::ST_RX_WAIT2: begin
                    if (dir_i) begin
                        new_read_o = is_in && link.turnaround;
                        state_d    = usb_proto_pkg::ST_RX_DATA;
                    end else if (timeout) begin
                        state_d = usb_proto_pkg::ST_IDLE;
                    end
                end
                usb_proto_pkg::ST_RX_DATA: begin
                    // first byte under nxt is the PID, the rest is payload
                    data_store_valid_o = is_in && dir_i && nxt_i && pid_seen_q;
                    if (rx_done) begin
                        state_d = data_ok ? usb_proto_pkg::ST_TX_WAIT
                                          : usb_proto_pkg::ST_TX_TURNAROUND;
                    end else if (timeout) begin
                        state_d = usb_proto_pkg::ST_IDLE;
                    end
                end
                usb_proto_pkg::ST_TX_WAIT: begin
                    if (!dir_i) begin
                        state_d = usb_proto_pkg::ST_TX_ACK;
                    end else if (timeout) begin
                        state_d = usb_proto_pkg::ST_IDLE;
                    end
                end
                usb_proto_pkg::ST_TX_ACK: begin
                    data_o = usb_proto_pkg::PID_ACK;
                    if (nxt_i) begin
                        state_d = usb_proto_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state_d = usb_proto_pkg::ST_IDLE;
                end
            endcase
        end
    end

    assign data_store_o = data_i;

    // ------------------------------------------------------------
    // registers
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= usb_proto_pkg::ST_IDLE;
            byte_cnt_q <= '0;
            timer_q    <= '0;
            pid_seen_q <= 1'b0;
        end else begin
            state_q <= state_d;
            timer_q <= (state_d != state_q) ? '0 : timer_q + 1'b1;
            if (state_q == usb_proto_pkg::ST_TX_PID) begin
                byte_cnt_q <= SETUP_LEN;
            end else if ((state_q == usb_proto_pkg::ST_TX_DATA) && nxt_i) begin
                byte_cnt_q <= byte_cnt_q - 1'b1;
            end
            if (state_q == usb_proto_pkg::ST_IDLE) begin
                pid_seen_q <= 1'b0;
            end else if ((state_q == usb_proto_pkg::ST_RX_DATA) && link.pid_strobe && nxt_i) begin
                pid_seen_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == usb_proto_pkg::ST_IDLE) && (state_d == usb_proto_pkg::ST_TX_TOKEN1)) begin
            kind_q <= sched.kind;
        end
        if ((state_q == usb_proto_pkg::ST_RX_DATA) && link.pid_strobe && nxt_i && !pid_seen_q) begin
            rx_pid_q <= data_i;
        end
    end

endmodule

// ==== source/usb_host_top.sv ====
module usb_host_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  data_i,
    input  logic        dir_i,
    input  logic        nxt_i,
    output logic [7:0]  data_o,
    output logic        stp_o,
    output logic        host_connect_o,
    output logic        new_read_o,
    output logic        data_store_valid_o,
    output logic [7:0]  data_store_o
);

    logic connect;
    logic connect_pulse;

    ulpi_link_if link_if ();
    usb_sched_if sched_if ();

    ulpi_rx_cmd_decoder ulpi_rx_cmd_decoder_inst (
        .clk             (clk),
        .rst             (rst),
        .data_i          (data_i),
        .dir_i           (dir_i),
        .nxt_i           (nxt_i),
        .link            (link_if.decoder),
        .connect_o       (connect),
        .connect_pulse_o (connect_pulse)
    );

    usb_transfer_sched usb_transfer_sched_inst (
        .clk             (clk),
        .rst             (rst),
        .connect_pulse_i (connect_pulse),
        .disconnect_i    (!connect),
        .sched           (sched_if.sched)
    );

    usb_packet_fsm usb_packet_fsm_inst (
        .clk                (clk),
        .rst                (rst),
        .data_i             (data_i),
        .dir_i              (dir_i),
        .nxt_i              (nxt_i),
        .link               (link_if.fsm),
        .sched              (sched_if.fsm),
        .connected_i        (connect),
        .data_o             (data_o),
        .stp_o              (stp_o),
        .new_read_o         (new_read_o),
        .data_store_valid_o (data_store_valid_o),
        .data_store_o       (data_store_o)
    );

    assign host_connect_o = connect;

endmodule

// ==== verification/usb_host_sva.sv ====
module usb_host_sva (
    input logic clk,
    input logic rst,
    input logic dir_i,
    input logic stp_o,
    input logic new_read_o,
    input logic data_store_valid_o
);

    // ------------------------------------------------------------
    // ULPI output rules
    // ------------------------------------------------------------

    // stp is a single-cycle strobe
    stp_single_cycle: assert property (@(posedge clk) disable iff (rst)
        stp_o |=> !stp_o)
        else $error("stp_o held for two cycles");

    // stores only while the PHY owns the bus
    store_needs_dir: assert property (@(posedge clk) disable iff (rst)
        data_store_valid_o |-> dir_i)
        else $error("data_store_valid_o high with dir_i low");

    // new read marks the dir rise only
    new_read_on_dir_rise: assert property (@(posedge clk) disable iff (rst)
        new_read_o |-> (dir_i && !$past(dir_i)))
        else $error("new_read_o without a rising dir_i");

endmodule

bind usb_host_top usb_host_sva usb_host_sva_inst (
    .clk                (clk),
    .rst                (rst),
    .dir_i              (dir_i),
    .stp_o              (stp_o),
    .new_read_o         (new_read_o),
    .data_store_valid_o (data_store_valid_o)
);

// ==== verification/usb_host_tb.sv ====
`include "usb_host_config.svh"

module usb_host_tb;

    logic        clk;
    logic        rst;
    logic [7:0]  data_i;
    logic        dir_i;
    logic        nxt_i;
    logic [7:0]  data_o;
    logic        stp_o;
    logic        host_connect_o;
    logic        new_read_o;
    logic        data_store_valid_o;
    logic [7:0]  data_store_o;

    logic [11:0] vec_mem [0:127];
    logic [7:0]  resp_q [$];
    logic [7:0]  store_q [$];
    integer      seed;
    int          new_read_cnt;
    int          cycle_cnt;
    int          cycle_limit;
    int          vec_count;

    usb_host_top usb_host_top_inst (
        .clk                (clk),
        .rst                (rst),
        .data_i             (data_i),
        .dir_i              (dir_i),
        .nxt_i              (nxt_i),
        .data_o             (data_o),
        .stp_o              (stp_o),
        .host_connect_o     (host_connect_o),
        .new_read_o         (new_read_o),
        .data_store_valid_o (data_store_valid_o),
        .data_store_o       (data_store_o)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // ------------------------------------------------------------
    // error handling and compare tasks
    // ------------------------------------------------------------

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [7:0] actual,
                              input logic [7:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s: got %b, expected %b", $time, name, actual, expected);
            abort_run();
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("run stopped at %0t, cycle limit %0d reached", $time, cycle_limit);
            abort_run();
        end
    end

    // receive side monitor, sampled before the edge updates the DUT
    always @(posedge clk) begin
        if (!rst && data_store_valid_o) begin
            store_q.push_back(data_store_o);
        end
        if (!rst && new_read_o) begin
            new_read_cnt <= new_read_cnt + 1;
        end
    end

    // ------------------------------------------------------------
    // PHY model, every task starts and ends on a falling edge
    // ------------------------------------------------------------

    task automatic send_rx_cmd(input logic [7:0] cmd);
        dir_i  = 1'b1;
        data_i = 8'h00;
        @(negedge clk);
        data_i = cmd;
        @(negedge clk);
        dir_i  = 1'b0;
        data_i = 8'h00;
        @(negedge clk);
    endtask

    task automatic accept_tx_byte(input logic [7:0] expected, input logic wait_start);
        int gap;
        gap = {$random(seed)} % 3;
        repeat (gap) @(negedge clk);
        if (wait_start) begin
            while (data_o == 8'h00) @(negedge clk);
        end
        check_byte("data_o", data_o, expected);
        nxt_i = 1'b1;
        @(negedge clk);
        nxt_i = 1'b0;
    endtask

    task automatic expect_stop();
        int n;
        n = 0;
        while (!stp_o && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (!stp_o) begin
            $display("stp_o did not pulse at %0t", $time);
            abort_run();
        end else begin
            @(negedge clk);
            check_bit("stp_o", stp_o, 1'b0);
        end
    endtask

    task automatic send_response();
        dir_i  = 1'b1;
        nxt_i  = 1'b0;
        data_i = 8'h00;
        @(negedge clk);
        foreach (resp_q[i]) begin
            data_i = resp_q[i];
            nxt_i  = 1'b1;
            @(negedge clk);
        end
        // closing RX_CMD with RxActive low
        data_i = 8'h00;
        nxt_i  = 1'b0;
        @(negedge clk);
        dir_i = 1'b0;
        @(negedge clk);
        resp_q.delete();
    endtask

    task automatic skip_to_pid(input logic [7:0] pid);
        while (data_o != pid) begin
            if (data_o != 8'h00) begin
                nxt_i = 1'b1;
                @(negedge clk);
                nxt_i = 1'b0;
            end else begin
                @(negedge clk);
            end
        end
    endtask

    task automatic stay_quiet(input logic [7:0] cycles);
        repeat (cycles) begin
            check_byte("data_o", data_o, 8'h00);
            check_bit("stp_o", stp_o, 1'b0);
            @(negedge clk);
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------

    initial begin
        logic [3:0] op;
        logic [7:0] arg;
        logic [7:0] stored;
        int         idx;

        rst          = 1'b1;
        data_i       = 8'h00;
        dir_i        = 1'b0;
        nxt_i        = 1'b0;
        seed         = 32'h18bc;
        new_read_cnt = 0;
        cycle_cnt    = 0;
        cycle_limit  = 2 * `USB_SOF_PERIOD;

        for (idx = 0; idx < 128; idx++) begin
            vec_mem[idx] = 12'h000;
        end
        $readmemh("verification/usb_host_vectors.txt", vec_mem);
        vec_count = 0;
        while (vec_count < 128 && vec_mem[vec_count][11:8] != 4'h0) begin
            vec_count++;
        end
        cycle_limit = vec_count * 200 + 2 * `USB_SOF_PERIOD;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_bit("host_connect_o", host_connect_o, 1'b0);
        check_bit("stp_o", stp_o, 1'b0);
        check_bit("new_read_o", new_read_o, 1'b0);
        check_bit("data_store_valid_o", data_store_valid_o, 1'b0);
        check_byte("data_o", data_o, 8'h00);
        @(negedge clk);

        for (idx = 0; idx < vec_count; idx++) begin
            op  = vec_mem[idx][11:8];
            arg = vec_mem[idx][7:0];
            case (op)
                4'h1: send_rx_cmd(arg);
                4'h2: accept_tx_byte(arg, 1'b1);
                4'h3: accept_tx_byte(arg, 1'b0);
                4'h4: expect_stop();
                4'h5: resp_q.push_back(arg);
                4'h6: send_response();
                4'h7: begin
                    if (store_q.size() == 0) begin
                        $display("expected stored byte %h but nothing was stored", arg);
                        abort_run();
                    end else begin
                        stored = store_q.pop_front();
                        check_byte("data_store_o", stored, arg);
                    end
                end
                4'h8: check_bit("host_connect_o", host_connect_o, arg[0]);
                4'h9: begin
                    check_byte("new_read_o pulses", 8'(new_read_cnt), arg);
                    new_read_cnt = 0;
                end
                4'hA: skip_to_pid(arg);
                4'hB: stay_quiet(arg);
                default: begin
                    $display("unknown vector opcode %h at entry %0d", op, idx);
                    abort_run();
                end
            endcase
        end

        if (store_q.size() != 0) begin
            $display("%0d stored bytes were never expected", store_q.size());
            $display("FAIL: see errors above");
            $fatal(1);
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// ==== usb_host_top.f ====
+incdir+source
source/ulpi_pkg.sv
source/usb_proto_pkg.sv
source/ulpi_link_if.sv
source/usb_sched_if.sv
source/ulpi_rx_cmd_decoder.sv
source/usb_transfer_sched.sv
source/usb_packet_fsm.sv
source/usb_host_top.sv
verification/usb_host_sva.sv
verification/usb_host_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the USB host testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing \
    -f usb_host_top.f \
    --top-module usb_host_tb \
    --Mdir "$OBJ" \
    -o usb_host_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/usb_host_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "PASS: all tests" "$LOG"; then
    echo "result: passed"
    exit 0
else
    echo "result: failed"
    exit 1
fi

// ==== verification/usb_host_vectors.txt ====
// word = {op, byte}  op 1 RXCMD, 2 wait for TX byte, 3 TX byte now, 4 stp, 5 RESP byte,
// 6 RESP send, 7 stored byte, 8 connect level, 9 new_read count, A skip to PID, B quiet, 0 end
// attach, line SE0 then J
100 101 801
// SET_ADDRESS, token to address 0 endpoint 0
24D 300 31F 400
243 300 305 301 300 300 300 300 300 3FF 3FF 400
542 600
// SET_CONFIGURATION, token to address 1
24D 302 31F 400
243 300 309 301 300 300 300 300 300 3FF 3FF 400
542 600
// SOF carrying frame 0
245 300 31F 400
// IN to address 1 endpoint 1, DATA1 with three bytes
249 303 31F 400
54B 5AA 5BB 5CC 600
7AA 7BB 7CC 901
242
// IN polling until the next frame, SOF carrying frame 1
A45 245 301 31F 400
// detach, no token afterwards
120 800 B64
000
